/* rv32i_macros.svh */
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// data and address width
`define XLEN 32

// fixed size of the control word carried down the pipe
`define CONTROL_WORD_SIZE 24

// control word field positions, msb:lsb
`define CW_ALUOP        2:0
`define CW_ALUMUX1      3:3
`define CW_ALUMUX2      5:4
`define CW_WBSEL        8:6
`define CW_LOAD_REGFILE 9:9
`define CW_MEM_READ     10:10
`define CW_MEM_WRITE    11:11
`define CW_FUNCT3       14:12   // load and store width
// bits 23:15 are spare and stay zero

`endif

/* rv32i_pkg.sv */
`include "rv32i_macros.svh"

package rv32i_pkg;

    typedef logic [`XLEN-1:0] rv32i_word;
    typedef logic [4:0] reg_idx;
    typedef logic [`CONTROL_WORD_SIZE-1:0] rv32i_control_word;
    typedef logic [3:0] byte_mask;

    // base opcodes handled by this pipe
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // same order as the arithmetic funct3 where they coincide
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    // first ALU operand
    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    // second ALU operand
    typedef enum logic [1:0] {
        alumux2_i_imm = 2'b00,
        alumux2_s_imm = 2'b01,
        alumux2_u_imm = 2'b10,
        alumux2_rs2   = 2'b11
    } alumux2_sel_t;

    // source of the register file write value
    typedef enum logic [2:0] {
        wb_alu_out = 3'b000,
        wb_slt     = 3'b001,
        wb_sltu    = 3'b010,
        wb_u_imm   = 3'b011,
        wb_load    = 3'b100
    } wb_sel_t;

endpackage

/* ir.sv */
`timescale 1ns/1ps

module ir import rv32i_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic load,
    input rv32i_word in,
    output rv32i_opcode opcode,
    output logic [2:0] funct3,
    output logic [6:0] funct7,
    output reg_idx rs1,
    output reg_idx rs2,
    output reg_idx rd,
    output rv32i_word i_imm,
    output rv32i_word s_imm,
    output rv32i_word u_imm
);

    localparam rv32i_word NOP = 32'h0000_0013;   // addi x0, x0, 0

    rv32i_word data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= NOP;
        end else if (load) begin
            data <= in;
        end
    end

    // register fields
    assign opcode = rv32i_opcode'(data[6:0]);
    assign rd     = data[11:7];
    assign funct3 = data[14:12];
    assign rs1    = data[19:15];
    assign rs2    = data[24:20];    // also the shamt of an immediate shift
    assign funct7 = data[31:25];

    // immediates, sign taken from bit 31
    assign i_imm = {{21{data[31]}}, data[30:20]};
    assign s_imm = {{21{data[31]}}, data[30:25], data[11:7]};
    assign u_imm = {data[31:12], 12'h000};

endmodule

/* control_unit.sv */
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module control_unit import rv32i_pkg::*; (
    input rv32i_opcode opcode,
    input logic [2:0] funct3,
    input logic [6:0] funct7,
    input reg_idx rs2,
    output rv32i_control_word ctrl_word
);

    logic alt;          // funct7 bit 5, picks sub and sra
    logic f7_ok;        // one of the two defined funct7 patterns
    logic shift_zero;   // srli or slli by zero
    logic arith_ok;
    alu_ops arith_op;
    wb_sel_t arith_wb;

    assign alt = funct7[5];
    assign f7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
    assign shift_zero = (opcode == op_imm) && (rs2 == 5'd0) &&
                        (funct3 == 3'b001 || (funct3 == 3'b101 && !alt));

    always_comb begin
        unique case (funct3)
            3'b000: arith_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
            3'b010, 3'b011: arith_op = alu_sub;     // compare via the difference
            3'b101: arith_op = alt ? alu_sra : alu_srl;
            default: arith_op = alu_ops'(funct3);
        endcase
        if (shift_zero) begin
            arith_op = alu_add;     // i_imm is zero here, so a plain copy
        end
        arith_wb = (funct3 == 3'b010) ? wb_slt : (funct3 == 3'b011) ? wb_sltu : wb_alu_out;
        if (opcode == op_reg) begin
            arith_ok = f7_ok && (!alt || funct3 == 3'b000 || funct3 == 3'b101);
        end else begin
            arith_ok = (funct3 == 3'b001) ? (funct7 == 7'b0) :
                       (funct3 == 3'b101) ? f7_ok : 1'b1;
        end
    end

    always_comb begin
        ctrl_word = '0;     // unsupported or reserved encodings do nothing
        unique case (opcode)
            op_lui: begin
                ctrl_word[`CW_WBSEL] = wb_u_imm;
                ctrl_word[`CW_LOAD_REGFILE] = 1'b1;
            end
            op_auipc: begin
                ctrl_word[`CW_ALUOP] = alu_add;
                ctrl_word[`CW_ALUMUX1] = alumux1_pc;
                ctrl_word[`CW_ALUMUX2] = alumux2_u_imm;
                ctrl_word[`CW_LOAD_REGFILE] = 1'b1;
            end
            op_load: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin    // lb lh lw lbu lhu
                    ctrl_word[`CW_ALUOP] = alu_add;
                    ctrl_word[`CW_WBSEL] = wb_load;
                    ctrl_word[`CW_LOAD_REGFILE] = 1'b1;
                    ctrl_word[`CW_MEM_READ] = 1'b1;
                    ctrl_word[`CW_FUNCT3] = funct3;
                end
            end
            op_store: begin
                if (!funct3[2] && funct3[1:0] != 2'b11) begin      // sb sh sw
                    ctrl_word[`CW_ALUOP] = alu_add;
                    ctrl_word[`CW_ALUMUX2] = alumux2_s_imm;
                    ctrl_word[`CW_MEM_WRITE] = 1'b1;
                    ctrl_word[`CW_FUNCT3] = funct3;
                end
            end
            op_imm, op_reg: begin
                if (arith_ok) begin
                    ctrl_word[`CW_ALUOP] = arith_op;
                    ctrl_word[`CW_ALUMUX2] = (opcode == op_reg) ? alumux2_rs2 : alumux2_i_imm;
                    ctrl_word[`CW_WBSEL] = arith_wb;
                    ctrl_word[`CW_LOAD_REGFILE] = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile import rv32i_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic load,
    input rv32i_word in,
    input reg_idx src_a,
    input reg_idx src_b,
    input reg_idx dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    rv32i_word data [32];   // entry 0 is never written
    logic wr_en;

    assign wr_en = load && (dest != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (wr_en) begin
            data[dest] <= in;
        end
    end

    // same-cycle write is forwarded to the reader
    assign reg_a = (wr_en && dest == src_a) ? in : data[src_a];
    assign reg_b = (wr_en && dest == src_b) ? in : data[src_b];

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import rv32i_pkg::*; (
    input alu_ops aluop,
    input rv32i_word a,
    input rv32i_word b,
    output rv32i_word f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // slt and sltu come out of alu_sub, finished in writeback
    always_comb begin
        unique case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << shamt;
            alu_sra: f = rv32i_word'($signed(a) >>> shamt);
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = a + b;
        endcase
    end

endmodule

/* load_masking.sv */
`timescale 1ns/1ps

module load_masking import rv32i_pkg::*; (
    input logic [2:0] funct3,
    input logic [1:0] addr_01,
    input rv32i_word mdr,
    output rv32i_word load_out
);

    logic [7:0] lane_b;
    logic [15:0] lane_h;

    always_comb begin
        unique case (addr_01)
            2'b00: lane_b = mdr[7:0];
            2'b01: lane_b = mdr[15:8];
            2'b10: lane_b = mdr[23:16];
            default: lane_b = mdr[31:24];
        endcase
        lane_h = addr_01[1] ? mdr[31:16] : mdr[15:0];  // halfwords are aligned
    end

    always_comb begin
        unique case (funct3)
            3'b000: load_out = {{24{lane_b[7]}}, lane_b};    // lb
            3'b001: load_out = {{16{lane_h[15]}}, lane_h};   // lh
            3'b100: load_out = {24'h0, lane_b};              // lbu
            3'b101: load_out = {16'h0, lane_h};              // lhu
            default: load_out = mdr;                         // lw
        endcase
    end

endmodule

/* datapath.sv */
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module datapath import rv32i_pkg::*; (
    input logic clk,
    input logic rst_n,
    input rv32i_word inst_rdata,
    output rv32i_word inst_addr,
    output logic inst_read,
    input rv32i_word data_rdata,
    output rv32i_word data_wdata,
    output rv32i_word data_addr,
    output byte_mask data_mbe,
    output logic data_read,
    output logic data_write
);

    rv32i_word pc, pc_id, pc_ex;
    rv32i_opcode opcode;
    logic [2:0] funct3, st_funct3;
    logic [6:0] funct7;
    reg_idx rs1, rs2, rd, rd_ex, rd_mem, rd_wb;
    rv32i_word i_imm, s_imm, u_imm, i_imm_ex, s_imm_ex, u_imm_ex, u_imm_mem, u_imm_wb;
    rv32i_control_word ctrl_word, cw_ex, cw_mem, cw_wb;
    rv32i_word rs1_out, rs2_out, rs1_ex, rs2_ex, rs2_mem;
    rv32i_word alumux1_out, alumux2_out, alu_out, alu_out_mem, alu_out_wb;
    logic a_msb_mem, b_msb_mem, a_msb_wb, b_msb_wb;   // operand signs for slt
    rv32i_word rdata_wb, load_out, wb_value;
    logic lt_signed, lt_unsigned;

    // fetch, memory answers in the same cycle
    assign inst_addr = pc;
    assign inst_read = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            cw_ex <= '0;
            cw_mem <= '0;
            cw_wb <= '0;
        end else begin
            pc <= pc + 32'd4;
            cw_ex <= ctrl_word;
            cw_mem <= cw_ex;
            cw_wb <= cw_mem;
        end
    end

    always_ff @(posedge clk) begin
        pc_id <= pc;
        pc_ex <= pc_id;
        {rd_ex, rs1_ex, rs2_ex} <= {rd, rs1_out, rs2_out};
        {i_imm_ex, s_imm_ex, u_imm_ex} <= {i_imm, s_imm, u_imm};
        {rd_mem, rs2_mem, u_imm_mem, alu_out_mem} <= {rd_ex, rs2_ex, u_imm_ex, alu_out};
        a_msb_mem <= alumux1_out[31];
        b_msb_mem <= alumux2_out[31];
        {rd_wb, u_imm_wb, alu_out_wb, rdata_wb} <= {rd_mem, u_imm_mem, alu_out_mem, data_rdata};
        {a_msb_wb, b_msb_wb} <= {a_msb_mem, b_msb_mem};
    end

    ir ir_inst (
        .clk(clk), .rst_n(rst_n), .load(1'b1), .in(inst_rdata),
        .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .i_imm(i_imm), .s_imm(s_imm), .u_imm(u_imm)
    );

    control_unit control_unit_inst (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .rs2(rs2), .ctrl_word(ctrl_word)
    );

    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n), .load(cw_wb[`CW_LOAD_REGFILE]), .in(wb_value),
        .src_a(rs1), .src_b(rs2), .dest(rd_wb), .reg_a(rs1_out), .reg_b(rs2_out)
    );

    // execute operands
    always_comb begin
        alumux1_out = (alumux1_sel_t'(cw_ex[`CW_ALUMUX1]) == alumux1_pc) ? pc_ex : rs1_ex;
        unique case (alumux2_sel_t'(cw_ex[`CW_ALUMUX2]))
            alumux2_s_imm: alumux2_out = s_imm_ex;
            alumux2_u_imm: alumux2_out = u_imm_ex;
            alumux2_rs2:   alumux2_out = rs2_ex;
            default:       alumux2_out = i_imm_ex;
        endcase
    end

    alu alu_inst (.aluop(alu_ops'(cw_ex[`CW_ALUOP])), .a(alumux1_out), .b(alumux2_out), .f(alu_out));

    // memory stage, store data copied into every lane it may use
    assign st_funct3 = cw_mem[`CW_FUNCT3];
    assign data_addr = {alu_out_mem[31:2], 2'b00};
    assign data_read = cw_mem[`CW_MEM_READ];
    assign data_write = cw_mem[`CW_MEM_WRITE];

    always_comb begin
        unique case (st_funct3[1:0])
            2'b00: begin
                data_mbe = byte_mask'(4'b0001 << alu_out_mem[1:0]);
                data_wdata = {4{rs2_mem[7:0]}};
            end
            2'b01: begin
                data_mbe = alu_out_mem[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{rs2_mem[15:0]}};
            end
            default: begin
                data_mbe = 4'b1111;
                data_wdata = rs2_mem;
            end
        endcase
    end

    load_masking load_masking_inst (
        .funct3(cw_wb[`CW_FUNCT3]), .addr_01(alu_out_wb[1:0]), .mdr(rdata_wb), .load_out(load_out)
    );

    // compare results from the difference and the operand signs
    assign lt_signed = (a_msb_wb != b_msb_wb) ? a_msb_wb : alu_out_wb[31];
    assign lt_unsigned = (a_msb_wb != b_msb_wb) ? b_msb_wb : alu_out_wb[31];

    always_comb begin
        unique case (wb_sel_t'(cw_wb[`CW_WBSEL]))
            wb_slt:   wb_value = {31'b0, lt_signed};
            wb_sltu:  wb_value = {31'b0, lt_unsigned};
            wb_u_imm: wb_value = u_imm_wb;
            wb_load:  wb_value = load_out;
            default:  wb_value = alu_out_wb;
        endcase
    end

endmodule

/* datapath_assertions.sv */
`timescale 1ns/1ps

module datapath_assertions import rv32i_pkg::*; (
    input logic clk,
    input logic rst_n,
    input rv32i_word inst_addr,
    input rv32i_word data_addr,
    input byte_mask data_mbe,
    input logic data_read,
    input logic data_write
);

    int fail_count;     // failed assertions so far

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else begin
            fail_count++;
            $error("data_read and data_write high in the same cycle");
        end

    // first cycle after reset has no previous pc
    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> inst_addr == $past(inst_addr) + 32'd4)
        else begin
            fail_count++;
            $error("inst_addr did not advance by 4");
        end

    strobes_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({data_read, data_write}))
        else begin
            fail_count++;
            $error("data strobes unknown outside reset");
        end

    store_known: assert property (@(posedge clk) disable iff (!rst_n)
        data_write |-> !$isunknown({data_addr, data_mbe}))
        else begin
            fail_count++;
            $error("store with unknown address or byte enables");
        end

endmodule

bind datapath datapath_assertions datapath_assertions_inst (.*);

/* datapath_tb.sv */
`timescale 1ns/1ps

module datapath_tb import rv32i_pkg::*; ();

    logic clk, rst_n;
    rv32i_word inst_rdata, inst_addr, data_rdata, data_wdata, data_addr;
    byte_mask data_mbe;
    logic inst_read, data_read, data_write;
    rv32i_word imem [256];
    logic is_load [256];        // program slot holds a load
    rv32i_word dmem [64];       // memory seen by the DUT
    rv32i_word mdl_mem [64];    // reference copy
    rv32i_word mdl_reg [32];
    rv32i_word exp_addr [$];
    rv32i_word exp_data [$];
    byte_mask exp_mbe [$];
    int prog_len, exp_total, store_count, cycle, mismatches, failures, waited;
    reg_idx last1, last2;       // destinations of the two previous instructions

    datapath datapath_inst (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign inst_rdata = imem[inst_addr[9:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    function automatic rv32i_word fill_word(input int i);
        return (i * 32'h9e37_79b1) ^ {4{i[7:0]}};
    endfunction

    function automatic rv32i_word lane_bits(input byte_mask m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // integer semantics of the ISA, f3 as in OP and OP-IMM
    function automatic rv32i_word isa_result(input logic [2:0] f3, input logic alt,
                                             input rv32i_word a, input rv32i_word b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // source register that the last two instructions did not write
    function automatic reg_idx pick_src();
        reg_idx r;
        do begin
            r = reg_idx'($urandom % 31);
        end while (r != 0 && (r == last1 || r == last2));
        return r;
    endfunction

    task automatic put(input rv32i_word inst, input reg_idx rd, input rv32i_word val);
        imem[prog_len] = inst;
        prog_len++;
        if (rd != 0) mdl_reg[rd] = val;     // x0 stays zero
        last2 = last1;
        last1 = rd;
    endtask

    task automatic add_random();
        reg_idx rd, ra, rb;
        logic [2:0] f3;
        logic alt;
        logic [11:0] imm;
        int off;
        rv32i_word addr, word, val;
        byte_mask mbe;
        rd = reg_idx'($urandom % 31);
        ra = pick_src();
        rb = pick_src();
        f3 = 3'($urandom);
        alt = 1'b0;
        imm = 12'($urandom);
        word = $urandom;
        case ($urandom % 8)
            0, 1: begin
                if (f3 == 0 || f3 == 5) alt = 1'($urandom);
                put({1'b0, alt, 5'b0, rb, ra, f3, rd, 7'b0110011}, rd,
                    isa_result(f3, alt, mdl_reg[ra], mdl_reg[rb]));
            end
            2, 3: begin
                if (f3 == 1 || f3 == 5) begin   // shamt form
                    alt = (f3 == 5) && 1'($urandom);
                    imm = {1'b0, alt, 5'b0, imm[4:0]};
                end
                put({imm, ra, f3, rd, 7'b0010011}, rd,
                    isa_result(f3, alt, mdl_reg[ra], {{20{imm[11]}}, imm}));
            end
            4: begin
                if (word[0]) begin
                    put({word[31:12], rd, 7'b0110111}, rd, {word[31:12], 12'h0});
                end else begin
                    put({word[31:12], rd, 7'b0010111}, rd,
                        {word[31:12], 12'h0} + prog_len * 4);
                end
            end
            5: begin    // load relative to x31, which holds 128
                f3 = (f3 == 3 || f3 >= 6) ? 3'd2 : f3;
                off = f3[1] ? 4 * ($urandom % 64) :
                      f3[0] ? 2 * ($urandom % 128) : $urandom % 256;
                addr = 32'(off);
                word = mdl_mem[addr[7:2]];
                val = word >> (8 * addr[1:0]);
                if (f3[1:0] == 2'b00) begin
                    val = f3[2] ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
                end else if (f3[1:0] == 2'b01) begin
                    val = f3[2] ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
                end
                imm = 12'(off - 128);
                is_load[prog_len] = 1'b1;
                put({imm, 5'd31, f3, rd, 7'b0000011}, rd, val);
            end
            default: begin
                f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
                off = f3[1] ? 4 * ($urandom % 64) :
                      f3[0] ? 2 * ($urandom % 128) : $urandom % 256;
                addr = 32'(off);
                mbe = f3[1] ? 4'b1111 : f3[0] ? 4'b0011 << addr[1:0] : 4'b0001 << addr[1:0];
                val = f3[1] ? mdl_reg[rb] :
                      f3[0] ? {2{mdl_reg[rb][15:0]}} : {4{mdl_reg[rb][7:0]}};
                mdl_mem[addr[7:2]] = (mdl_mem[addr[7:2]] & ~lane_bits(mbe)) |
                                     (val & lane_bits(mbe));
                exp_addr.push_back({addr[31:2], 2'b00});
                exp_mbe.push_back(mbe);
                exp_data.push_back(val);
                exp_total++;
                imm = 12'(off - 128);
                put({imm[11:5], rb, 5'd31, f3, imm[4:0], 7'b0100011}, 5'd0, '0);
            end
        endcase
    endtask

    task automatic build_program();
        rv32i_word word;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            is_load[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            mdl_mem[i] = fill_word(i);
            dmem[i] = fill_word(i);
        end
        mdl_reg = '{default: '0};
        put({12'd128, 5'd0, 3'b000, 5'd31, 7'b0010011}, 5'd31, 32'd128);   // data base
        for (int r = 1; r < 31; r++) begin
            word = $urandom;
            if (word[0]) begin
                put({word[31:12], reg_idx'(r), 7'b0110111}, reg_idx'(r),
                    {word[31:12], 12'h0});
            end else begin
                put({word[31:20], 5'd0, 3'b000, reg_idx'(r), 7'b0010011}, reg_idx'(r),
                    {{20{word[31]}}, word[31:20]});
            end
        end
        for (int n = 0; n < 200; n++) add_random();
    endtask

    task automatic check_store();
        rv32i_word ea, ed, m;
        byte_mask em;
        store_count++;
        if (exp_addr.size() == 0) begin
            failures++;
            $display("store to %h at %0t has no matching store in the model", data_addr, $time);
        end else begin
            ea = exp_addr.pop_front();
            em = exp_mbe.pop_front();
            ed = exp_data.pop_front();
            m = lane_bits(em);
            if (data_addr !== ea) begin
                mismatches++;
                $display("MISMATCH t=%0t data_addr expected %h got %h", $time, ea, data_addr);
            end
            if (data_mbe !== em) begin
                mismatches++;
                $display("MISMATCH t=%0t data_mbe expected %b got %b", $time, em, data_mbe);
            end
            if ((data_wdata & m) !== (ed & m)) begin   // enabled lanes only
                mismatches++;
                $display("MISMATCH t=%0t data_wdata expected %h got %h", $time,
                         ed & m, data_wdata & m);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (inst_addr !== 32'(cycle * 4)) begin
                mismatches++;
                $display("MISMATCH t=%0t inst_addr expected %h got %h", $time, cycle * 4, inst_addr);
            end
            if (inst_read !== 1'b1) begin
                mismatches++;
                $display("MISMATCH t=%0t inst_read expected 1 got %b", $time, inst_read);
            end
            if (cycle < 3 && (data_read !== 1'b0 || data_write !== 1'b0)) begin
                failures++;
                $display("memory strobe active %0d cycles after reset at %0t", cycle, $time);
            end
            // instruction in MEM was fetched three cycles earlier
            if (cycle >= 3 && data_read !== is_load[8'(cycle - 3)]) begin
                mismatches++;
                $display("MISMATCH t=%0t data_read expected %b got %b", $time,
                         is_load[8'(cycle - 3)], data_read);
            end
            if (data_write === 1'b1) begin
                check_store();
                for (int k = 0; k < 4; k++) begin
                    if (data_mbe[k]) dmem[data_addr[7:2]][8*k +: 8] <= data_wdata[8*k +: 8];
                end
            end
            cycle++;
        end
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h4ad7_025d));
        build_program();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // run past the last instruction so the pipe drains
        while (inst_addr < 32'((prog_len + 6) * 4) && waited < 400) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 400) begin
            failures++;
            $display("timeout before the program finished");
        end
        if (exp_addr.size() != 0) begin
            failures++;
            $display("%0d expected stores never appeared", exp_addr.size());
        end
        if (store_count != exp_total) begin
            failures++;
            $display("store count %0d differs from model count %0d", store_count, exp_total);
        end
        if (datapath_inst.datapath_assertions_inst.fail_count != 0) begin
            failures++;
            $display("%0d assertion failures on the memory ports",
                     datapath_inst.datapath_assertions_inst.fail_count);
        end
        $display("stores %0d, mismatches %0d, other errors %0d", store_count, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
rv32i_pkg.sv
ir.sv
control_unit.sv
regfile.sv
alu.sv
load_masking.sv
datapath.sv
datapath_assertions.sv
datapath_tb.sv
